// ==== bench/tb_data_memory.sv ====
// Testbench for the RV32I data memory block
// Mirrors every store in a byte-level reference model and checks load
// results, PWM duty cycles and timer rates with assertions
`timescale 1ns/10ps
`default_nettype none

module tb_data_memory;
    import mem_pkg::*;

    localparam int    DEPTH       = 1024;
    localparam word_t LED_ADDR    = 32'hFFFF_FFFC;
    localparam word_t MILLIS_ADDR = 32'hFFFF_FFF8;
    localparam word_t MICROS_ADDR = 32'hFFFF_FFF4;

    logic       clk;
    logic       rst;
    logic       wren;
    logic [2:0] funct3;
    word_t      address;
    word_t      wdata;
    word_t      rdata;
    logic       led;
    logic       red;
    logic       green;
    logic       blue;
    logic       check_now;
    logic       chk_q;
    word_t      expected;
    word_t      exp_q;
    byte_t      ref_mem [4*DEPTH];
    byte_t      ref_duty [4];
    string      names [4] = '{"blue", "green", "red", "led"};
    int         seed = 17423;
    int         errors = 0;
    int         checks = 0;

    data_memory #(
        .DEPTH_WORDS (DEPTH),
        .CLK_FREQ    (4_000_000)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .address (address),
        .wdata   (wdata),
        .wren    (wren),
        .funct3  (funct3),
        .rdata   (rdata),
        .led     (led),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        chk_q <= check_now;
        exp_q <= expected;
    end

    // A load result holds from the edge after the address until the next edge
    assert property (@(negedge clk) disable iff (rst) chk_q |-> rdata == exp_q)
        else begin
            errors++;
            $display("FAIL t=%0t rdata expected %h got %h", $time, exp_q, rdata);
        end

    // Word seen at the address, then the byte or half picked out and extended
    function automatic word_t expect_load(input word_t addr, input logic [2:0] f3);
        int    base;
        word_t w;
        byte_t b;
        logic [15:0] h;
        base = {addr[31:2], 2'b00};
        if (addr < 4*DEPTH) begin
            w = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
        end else if (addr[31:2] == LED_ADDR[31:2]) begin
            w = {ref_duty[3], ref_duty[2], ref_duty[1], ref_duty[0]};
        end else begin
            w = '0;
        end
        b = w[8*addr[1:0] +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b100:  return {24'b0, b};
            3'b101:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic store(input word_t addr, input logic [2:0] f3, input word_t data);
        int         base;
        logic [3:0] lanes;
        byte_t      b;
        base = {addr[31:2], 2'b00};
        if (f3[1:0] == 2'b10) begin
            lanes = 4'b1111;
        end else if (f3[1:0] == 2'b01) begin
            lanes = addr[1] ? 4'b1100 : 4'b0011;
        end else begin
            lanes = 4'b0001 << addr[1:0];
        end
        for (int i = 0; i < 4; i++) begin
            b = (f3[1:0] == 2'b10) ? data[8*i +: 8] :
                (f3[1:0] == 2'b01) ? data[8*(i%2) +: 8] : data[7:0];
            if (lanes[i] && addr < 4*DEPTH) begin
                ref_mem[base+i] = b;
            end else if (lanes[i] && addr[31:2] == LED_ADDR[31:2]) begin
                ref_duty[i] = b;
            end
        end
        address = addr;
        wdata = data;
        funct3 = f3;
        wren = 1'b1;
        check_now = 1'b0;
        @(negedge clk);
        wren = 1'b0;
    endtask

    task automatic check_load(input word_t addr, input logic [2:0] f3);
        address = addr;
        funct3 = f3;
        expected = expect_load(addr, f3);
        check_now = 1'b1;
        checks++;
        @(negedge clk);
        check_now = 1'b0;
    endtask

    task automatic read_word(input word_t addr, output word_t val);
        address = addr;
        funct3 = 3'b010;
        check_now = 1'b0;
        @(negedge clk);
        val = rdata;
    endtask

    task automatic check_narrow_loads(input word_t addr);
        check_load(addr, 3'b010);
        for (int off = 0; off < 4; off++) begin
            check_load(addr + off, 3'b000);
            check_load(addr + off, 3'b100);
            if (off % 2 == 0) begin
                check_load(addr + off, 3'b001);
                check_load(addr + off, 3'b101);
            end
        end
    endtask

    // Counts the high cycles of each output over one full PWM period
    task automatic measure_pwm();
        int         high [4];
        logic [3:0] outs;
        high = '{0, 0, 0, 0};
        repeat (256) begin
            @(negedge clk);
            outs = {led, red, green, blue};
            for (int i = 0; i < 4; i++) begin
                high[i] += int'(outs[i]);
            end
        end
        for (int i = 0; i < 4; i++) begin
            checks++;
            assert (high[i] == int'(ref_duty[i])) else begin
                errors++;
                $display("FAIL t=%0t %s high cycles expected %0d got %0d",
                         $time, names[i], ref_duty[i], high[i]);
            end
        end
    endtask

    task automatic check_rate(input word_t addr, input int gap, input int nominal,
                              input string name);
        word_t first;
        word_t second;
        int    diff;
        read_word(addr, first);
        repeat (gap - 1) @(negedge clk);
        read_word(addr, second);
        diff = int'(second - first);
        checks++;
        assert (diff >= nominal - 1 && diff <= nominal + 1) else begin
            errors++;
            $display("FAIL t=%0t %s delta expected %0d got %0d", $time, name, nominal, diff);
        end
    endtask

    task automatic wait_micros_running();
        word_t val;
        int    tries;
        val = '0;
        tries = 0;
        while (val == 0 && tries < 20) begin
            read_word(MICROS_ADDR, val);
            tries++;
        end
        if (val == 0) begin
            errors++;
            $display("Timeout while waiting for the microsecond counter to start");
        end
    endtask

    initial begin
        int idx [16];
        rst = 1'b1;
        wren = 1'b0;
        address = '0;
        wdata = '0;
        funct3 = 3'b010;
        check_now = 1'b0;
        expected = '0;
        ref_duty = '{8'h00, 8'h00, 8'h00, 8'h00};
        repeat (3) @(negedge clk);
        rst = 1'b0;

        measure_pwm();
        check_load(LED_ADDR, 3'b010);

        for (int i = 0; i < 16; i++) begin
            idx[i] = {$random(seed)} % DEPTH;
            store(word_t'(idx[i] * 4), 3'b010, $random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            check_load(word_t'(idx[i] * 4), 3'b010);
        end

        // Fixed bytes give both signs in every lane and half
        store(32'h0000_0100, 3'b010, 32'h1234_5678);
        store(32'h0000_0101, 3'b000, 32'h0000_0080);
        store(32'h0000_0102, 3'b001, 32'h0000_F00F);
        check_narrow_loads(32'h0000_0100);
        for (int off = 0; off < 4; off++) begin
            store(32'h0000_0104 + off, 3'b000, $random(seed));
        end
        store(32'h0000_0106, 3'b001, $random(seed));
        check_narrow_loads(32'h0000_0104);

        // Both unmapped addresses alias RAM index 0 if the decode is wrong
        for (int i = 0; i < 4; i++) begin
            store(word_t'(4 * i), 3'b010, $random(seed));
        end
        check_load(32'h0000_2000, 3'b010);
        check_load(32'h8000_0000, 3'b010);
        store(32'h0000_2000, 3'b010, 32'hDEAD_BEEF);
        store(32'h8000_0000, 3'b010, 32'hCAFE_F00D);
        for (int i = 0; i < 4; i++) begin
            check_load(word_t'(4 * i), 3'b010);
        end

        store(LED_ADDR, 3'b010, 32'h1020_3040);
        check_load(LED_ADDR, 3'b010);
        store(LED_ADDR + 1, 3'b000, 32'h0000_00FF);
        store(LED_ADDR + 2, 3'b001, 32'h0000_0180);
        check_narrow_loads(LED_ADDR);
        measure_pwm();

        wait_micros_running();
        check_rate(MICROS_ADDR, 40, 10, "micros");
        check_rate(MILLIS_ADDR, 8000, 2, "millis");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("Timeout: the simulation ran past its cycle limit");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/mem_pkg.sv
source/access_decode.sv
source/byte_lane_ram.sv
source/led_pwm.sv
source/tick_timer.sv
source/load_align.sv
source/data_memory.sv
bench/tb_data_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the data memory testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_data_memory -f build.f -o tb_data_memory
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_data_memory > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
    echo "Simulation log holds no pass message"
    exit 1
fi
exit 0

// ==== source/access_decode.sv ====
// Access decoder for the data memory
// Maps the address onto RAM or a peripheral, builds the per-lane
// write enables and moves store data onto the addressed lanes
`timescale 1ns/10ps
`default_nettype none

module access_decode #(
    parameter int DEPTH_WORDS = 1024
) (
    input  mem_pkg::word_t                 address,
    input  mem_pkg::word_t                 wdata,
    input  logic                           wren,
    input  logic [2:0]                     funct3,
    output mem_pkg::region_e               region,
    output mem_pkg::lane_mask_t            lane_we,
    output mem_pkg::word_t                 lane_wdata,
    output logic [$clog2(DEPTH_WORDS)-1:0] ram_index
);
    import mem_pkg::*;

    access_size_e size;
    lane_mask_t   lane_sel;
    logic         writable;

    assign size      = access_size_e'(funct3[1:0]);
    assign ram_index = address[$clog2(DEPTH_WORDS)+1:2];

    always_comb begin
        if (address[DATA_W-1:2] < 30'(DEPTH_WORDS)) begin
            region = REGION_RAM;
        end else if (address[DATA_W-1:2] == LEDS_WORD) begin
            region = REGION_LED;
        end else if (address[DATA_W-1:2] == MILLIS_WORD) begin
            region = REGION_MILLIS;
        end else if (address[DATA_W-1:2] == MICROS_WORD) begin
            region = REGION_MICROS;
        end else begin
            region = REGION_NONE;
        end
    end

    // Narrow stores replicate their data so every candidate lane sees it
    always_comb begin
        unique case (size)
            SIZE_BYTE: begin
                lane_sel   = lane_mask_t'(1) << address[1:0];
                lane_wdata = {LANES{wdata[BYTE_W-1:0]}};
            end
            SIZE_HALF: begin
                lane_sel   = address[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{wdata[2*BYTE_W-1:0]}};
            end
            default: begin
                lane_sel   = '1;
                lane_wdata = wdata;
            end
        endcase
    end

    // Counters are read-only, so only RAM and the LED register take stores
    assign writable = region[RGN_RAM_BIT] | region[RGN_LED_BIT];
    assign lane_we  = lane_sel & {LANES{wren & writable}};

    always_comb begin
        if (!$isunknown({address, funct3})) begin
            if (region != REGION_NONE) begin
                assert final (size != SIZE_HALF || !address[0])
                    else $error("access_decode: misaligned half access");
                assert final (size != SIZE_WORD || address[1:0] == 2'b00)
                    else $error("access_decode: misaligned word access");
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/byte_lane_ram.sv ====
// One byte lane of the data RAM
// Synchronous single-port bank, reads only in cycles without a write
`timescale 1ns/10ps
`default_nettype none

module byte_lane_ram #(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                           clk,
    input  logic                           we,
    input  logic [$clog2(DEPTH_WORDS)-1:0] index,
    input  mem_pkg::byte_t                 wdata,
    output mem_pkg::byte_t                 rdata
);
    import mem_pkg::*;

    byte_t mem [DEPTH_WORDS];

    // A write cycle leaves rdata holding the previous read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end else begin
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== source/data_memory.sv ====
// Data memory for a small RV32I core
// Byte-addressed RAM from address zero plus an LED PWM register and
// millisecond and microsecond counters at the top of the address space
// Unmapped reads return zero and unmapped writes are dropped
`timescale 1ns/10ps
`default_nettype none

module data_memory #(
    parameter int DEPTH_WORDS = 1024,
    parameter int CLK_FREQ    = 10_000_000
) (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::word_t address,
    input  mem_pkg::word_t wdata,
    input  logic           wren,
    input  logic [2:0]     funct3,
    output mem_pkg::word_t rdata,
    output logic           led,
    output logic           red,
    output logic           green,
    output logic           blue
);
    import mem_pkg::*;

    localparam int TICKS_MS = CLK_FREQ / 1000;
    localparam int TICKS_US = CLK_FREQ / 1_000_000;
    localparam int IDX_W    = $clog2(DEPTH_WORDS);

    region_e           region;
    lane_mask_t        lane_we;
    lane_mask_t        ram_we;
    lane_mask_t        led_we;
    word_t             lane_wdata;
    logic [IDX_W-1:0]  ram_index;
    word_t             ram_word;
    word_t             duty;
    word_t             millis;
    word_t             micros;

    access_decode #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_decode (
        .address    (address),
        .wdata      (wdata),
        .wren       (wren),
        .funct3     (funct3),
        .region     (region),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .ram_index  (ram_index)
    );

    // Route lane enables to the selected target only
    assign ram_we = lane_we & {LANES{region[RGN_RAM_BIT]}};
    assign led_we = lane_we & {LANES{region[RGN_LED_BIT]}};

    for (genvar i = 0; i < LANES; i++) begin : g_bank
        byte_lane_ram #(
            .DEPTH_WORDS (DEPTH_WORDS)
        ) u_bank (
            .clk   (clk),
            .we    (ram_we[i]),
            .index (ram_index),
            .wdata (lane_wdata[i*BYTE_W +: BYTE_W]),
            .rdata (ram_word[i*BYTE_W +: BYTE_W])
        );
    end

    led_pwm u_led_pwm (
        .clk        (clk),
        .rst        (rst),
        .lane_we    (led_we),
        .lane_wdata (lane_wdata),
        .duty       (duty),
        .led        (led),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    tick_timer #(.TICKS(TICKS_MS)) millis_timer (.clk(clk), .rst(rst), .count(millis));
    tick_timer #(.TICKS(TICKS_US)) micros_timer (.clk(clk), .rst(rst), .count(micros));

    load_align u_align (
        .clk         (clk),
        .rst         (rst),
        .funct3      (funct3),
        .byte_offset (address[1:0]),
        .region      (region),
        .ram_word    (ram_word),
        .duty        (duty),
        .millis      (millis),
        .micros      (micros),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

// ==== source/led_pwm.sv ====
// LED PWM peripheral
// Four 8-bit duty bytes (blue, green, red, user LED from lane 0 up)
// compared against a shared free-running 8-bit counter
`timescale 1ns/10ps
`default_nettype none

module led_pwm (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::lane_mask_t lane_we,
    input  mem_pkg::word_t      lane_wdata,
    output mem_pkg::word_t      duty,
    output logic                led,
    output logic                red,
    output logic                green,
    output logic                blue
);
    import mem_pkg::*;

    logic [BYTE_W-1:0] pwm_cnt;
    logic [LANES-1:0]  pwm_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            duty <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_we[i]) begin
                    duty[i*BYTE_W +: BYTE_W] <= lane_wdata[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // Wraps every 256 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_pwm
        assign pwm_out[i] = pwm_cnt < duty[i*BYTE_W +: BYTE_W];

        // A pulse starts with the counter period unless its duty byte just changed
        assert property (@(posedge clk) disable iff (rst)
            $rose(pwm_out[i]) |-> pwm_cnt == '0 || $changed(duty[i*BYTE_W +: BYTE_W]))
            else $error("led_pwm: lane %0d rose in the middle of a period", i);
    end

    assign {led, red, green, blue} = pwm_out;

endmodule

`default_nettype wire

// ==== source/load_align.sv ====
// Load result path
// Registers the access attributes, then picks RAM or peripheral data
// and extends the addressed byte or half word to 32 bits
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input  logic             clk,
    input  logic             rst,
    input  logic [2:0]       funct3,
    input  logic [1:0]       byte_offset,
    input  mem_pkg::region_e region,
    input  mem_pkg::word_t   ram_word,
    input  mem_pkg::word_t   duty,
    input  mem_pkg::word_t   millis,
    input  mem_pkg::word_t   micros,
    output mem_pkg::word_t   rdata
);
    import mem_pkg::*;

    localparam int HALF_W = 2 * BYTE_W;

    access_size_e      size_q;
    logic              zext_q;
    logic [1:0]        offset_q;
    region_e           region_q;
    word_t             src;
    logic [BYTE_W-1:0] sel_byte;
    logic [HALF_W-1:0] sel_half;

    always_ff @(posedge clk) begin
        if (rst) begin
            size_q   <= SIZE_WORD;
            zext_q   <= 1'b0;
            offset_q <= 2'b00;
            region_q <= REGION_NONE;
        end else begin
            size_q   <= access_size_e'(funct3[1:0]);
            zext_q   <= funct3[2];
            offset_q <= byte_offset;
            region_q <= region;
        end
    end

    // Peripheral values are taken live, one cycle after the address
    always_comb begin
        case (region_q)
            REGION_RAM:    src = ram_word;
            REGION_LED:    src = duty;
            REGION_MILLIS: src = millis;
            REGION_MICROS: src = micros;
            default:       src = '0;
        endcase
    end

    assign sel_byte = src[offset_q*BYTE_W +: BYTE_W];
    assign sel_half = offset_q[1] ? src[DATA_W-1:HALF_W] : src[HALF_W-1:0];

    always_comb begin
        case (size_q)
            SIZE_BYTE: rdata = {{(DATA_W-BYTE_W){~zext_q & sel_byte[BYTE_W-1]}}, sel_byte};
            SIZE_HALF: rdata = {{(DATA_W-HALF_W){~zext_q & sel_half[HALF_W-1]}}, sel_half};
            default:   rdata = src;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
// Shared definitions for the RV32I data memory block
// Word and lane widths, access sizes, the one-hot target select
// and the word addresses of the memory-mapped peripherals
`default_nettype none

package mem_pkg;

    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int LANES  = DATA_W / BYTE_W;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [LANES-1:0]  lane_mask_t;

    // Low two bits of funct3
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // Bit positions inside the one-hot region select
    localparam int RGN_RAM_BIT    = 0;
    localparam int RGN_LED_BIT    = 1;
    localparam int RGN_MILLIS_BIT = 2;
    localparam int RGN_MICROS_BIT = 3;

    typedef enum logic [3:0] {
        REGION_NONE   = 4'b0000,
        REGION_RAM    = 4'b0001,
        REGION_LED    = 4'b0010,
        REGION_MILLIS = 4'b0100,
        REGION_MICROS = 4'b1000
    } region_e;

    // Peripheral word addresses at 0xFFFFFFFC, 0xFFFFFFF8 and 0xFFFFFFF4
    localparam logic [29:0] LEDS_WORD   = 30'h3FFF_FFFF;
    localparam logic [29:0] MILLIS_WORD = 30'h3FFF_FFFE;
    localparam logic [29:0] MICROS_WORD = 30'h3FFF_FFFD;

endpackage

`default_nettype wire

// ==== source/tick_timer.sv ====
// Free-running elapsed time counter
// A prescaler divides the clock by TICKS and advances a 32-bit count
`timescale 1ns/10ps
`default_nettype none

module tick_timer #(
    parameter int TICKS = 1000
) (
    input  logic           clk,
    input  logic           rst,
    output mem_pkg::word_t count
);
    import mem_pkg::*;

    localparam int PRE_W = (TICKS > 1) ? $clog2(TICKS) : 1;

    logic [PRE_W-1:0] prescale;
    logic             wrap;

    assign wrap = (prescale == PRE_W'(TICKS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
            count    <= '0;
        end else if (wrap) begin
            prescale <= '0;
            count    <= count + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

`default_nettype wire
